/* verilog/mpu_pkg.sv */
package mpu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // PMA region description
  ////////////////////////////////////////////////////////////////////////////

  // Bounds are word addresses, low inclusive and high exclusive
  typedef struct packed {
    logic [29:0] word_addr_low;
    logic [29:0] word_addr_high;
    logic        main;
    logic        atomic;
    logic        bufferable;
    logic        cacheable;
  } pma_cfg_t;

  // Attributes when no table is configured at all
  localparam pma_cfg_t PMA_R_DEFAULT = '{word_addr_low:  30'h0,
                                         word_addr_high: 30'h0,
                                         main:           1'b1,
                                         atomic:         1'b1,
                                         bufferable:     1'b0,
                                         cacheable:      1'b0};

  // Attributes for an address outside every configured region
  localparam pma_cfg_t NO_PMA_R_DEFAULT = '{word_addr_low:  30'h0,
                                            word_addr_high: 30'h0,
                                            main:           1'b0,
                                            atomic:         1'b0,
                                            bufferable:     1'b0,
                                            cacheable:      1'b0};

  localparam int PMA_MAX_REGIONS = 16;

  ////////////////////////////////////////////////////////////////////////////
  // MPU control types
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    MPU_IDLE      = 2'd0,
    MPU_WAIT_RESP = 2'd1,
    MPU_ERR_RESP  = 2'd2
  } mpu_state_e;

  typedef enum logic {
    MPU_OK  = 1'b0,
    MPU_ERR = 1'b1
  } mpu_status_e;

endpackage

/* verilog/mpu_bus_if.sv */
`timescale 1ns/100ps

// One checked transaction from the MPU towards the bus port
interface mpu_bus_if;

  // Request channel
  logic        trans_valid;
  logic        trans_ready;
  logic [31:0] addr;
  logic        we;
  logic [31:0] wdata;
  logic [1:0]  memtype;

  // Response channel
  logic        resp_valid;
  logic [31:0] resp_data;
  logic        resp_outstanding;

  // MPU side
  modport master (
    output trans_valid, addr, we, wdata, memtype,
    input  trans_ready, resp_valid, resp_data, resp_outstanding
  );

  // Bus port side
  modport slave (
    input  trans_valid, addr, we, wdata, memtype,
    output trans_ready, resp_valid, resp_data, resp_outstanding
  );

endinterface

/* verilog/pma_lookup.sv */
`timescale 1ns/100ps

module pma_lookup import mpu_pkg::*; #(
  parameter int       PMA_NUM_REGIONS = 0,
  parameter pma_cfg_t PMA_CFG [PMA_NUM_REGIONS-1:0] = '{default: PMA_R_DEFAULT}
) (
  input  logic [31:0] addr_i,
  input  logic        atomic_i,
  input  logic        misaligned_i,
  output pma_cfg_t    pma_cfg_o,
  output logic        pma_err_o
);

  logic [29:0]                word_addr;
  logic [PMA_MAX_REGIONS-1:0] region_hit;
  logic                       hit_any;

  assign word_addr = addr_i[31:2];

  ////////////////////////////////////////////////////////////////////////////
  // Region match
  ////////////////////////////////////////////////////////////////////////////

  // Entries past the region limit are never looked at
  always_comb begin
    region_hit = '0;
    for (int i = 0; i < PMA_NUM_REGIONS; i++) begin
      if (i < PMA_MAX_REGIONS) begin
        region_hit[i] = (word_addr >= PMA_CFG[i].word_addr_low) &&
                        (word_addr <  PMA_CFG[i].word_addr_high);
      end
    end
  end

  // Lowest index wins when regions overlap
  always_comb begin
    hit_any   = 1'b0;
    pma_cfg_o = (PMA_NUM_REGIONS == 0) ? PMA_R_DEFAULT : NO_PMA_R_DEFAULT;
    for (int i = 0; i < PMA_NUM_REGIONS; i++) begin
      if ((i < PMA_MAX_REGIONS) && region_hit[i] && !hit_any) begin
        pma_cfg_o = PMA_CFG[i];
        hit_any   = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Access check
  ////////////////////////////////////////////////////////////////////////////

  // Misaligned I/O, atomics outside atomic regions and unmatched addresses are refused
  assign pma_err_o = (misaligned_i && !pma_cfg_o.main) ||
                     (atomic_i && !pma_cfg_o.atomic) ||
                     ((PMA_NUM_REGIONS > 0) && !hit_any);

endmodule

/* verilog/mpu_ctrl.sv */
`timescale 1ns/100ps

module mpu_ctrl import mpu_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,

  // Core request
  input  logic         core_valid_i,
  output logic         core_ready_o,
  input  logic [31:0]  core_addr_i,
  input  logic         core_we_i,
  input  logic         core_atomic_i,
  input  logic [31:0]  core_wdata_i,

  // Core response
  output logic         core_rvalid_o,
  output logic [31:0]  core_rdata_o,
  output mpu_status_e  core_status_o,

  // PMA lookup
  input  pma_cfg_t     pma_cfg_i,
  input  logic         pma_err_i,
  output logic         misaligned_o,
  output logic         atomic_o,

  // Towards bus port
  mpu_bus_if.master    bus
);

  mpu_state_e state_q;
  mpu_state_e state_n;
  logic       mpu_err;
  logic       mpu_block_core;
  logic       mpu_block_bus;
  logic       mpu_err_trans_valid;
  logic       bufferable;

  // Word accesses only, any low address bit set is misaligned
  assign misaligned_o = (core_addr_i[1:0] != 2'b00);
  assign atomic_o     = core_atomic_i;

  assign mpu_err = core_valid_i && pma_err_i;

  ////////////////////////////////////////////////////////////////////////////
  // Error FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_n             = state_q;
    mpu_block_core      = 1'b0;
    mpu_block_bus       = 1'b0;
    mpu_err_trans_valid = 1'b0;
    case (state_q)
      MPU_IDLE: begin
        if (mpu_err) begin
          mpu_block_bus = 1'b1;
          // Keep responses in order behind a pending bus response
          if (bus.resp_outstanding && !bus.resp_valid) begin
            state_n = MPU_WAIT_RESP;
          end else begin
            state_n = MPU_ERR_RESP;
          end
        end
      end
      MPU_WAIT_RESP: begin
        mpu_block_core = 1'b1;
        mpu_block_bus  = 1'b1;
        if (bus.resp_valid) begin
          state_n = MPU_ERR_RESP;
        end
      end
      MPU_ERR_RESP: begin
        mpu_block_core      = 1'b1;
        mpu_block_bus       = 1'b1;
        mpu_err_trans_valid = 1'b1;
        state_n             = MPU_IDLE;
      end
      default: begin
        state_n = MPU_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MPU_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request and response paths
  ////////////////////////////////////////////////////////////////////////////

  // A refused request is consumed at once; the bus never sees it
  assign core_ready_o = !mpu_block_core && (mpu_err || bus.trans_ready);

  // Loads and atomics are never bufferable
  assign bufferable = core_we_i && !core_atomic_i && pma_cfg_i.bufferable;

  assign bus.trans_valid = core_valid_i && !mpu_block_bus;
  assign bus.addr        = core_addr_i;
  assign bus.we          = core_we_i;
  assign bus.wdata       = core_wdata_i;
  assign bus.memtype     = {pma_cfg_i.cacheable, bufferable};

  // Bus and error responses never fall in the same cycle
  assign core_rvalid_o = bus.resp_valid || mpu_err_trans_valid;
  assign core_rdata_o  = mpu_err_trans_valid ? 32'h0 : bus.resp_data;
  assign core_status_o = mpu_err_trans_valid ? MPU_ERR : MPU_OK;

endmodule

/* verilog/obi_port.sv */
`timescale 1ns/100ps

module obi_port (
  input  logic         clk,
  input  logic         rst_n,

  // From the MPU
  mpu_bus_if.slave     bus,

  // OBI request
  output logic         obi_req_o,
  input  logic         obi_gnt_i,
  output logic [31:0]  obi_addr_o,
  output logic         obi_we_o,
  output logic [31:0]  obi_wdata_o,
  output logic [1:0]   obi_memtype_o,

  // OBI response
  input  logic         obi_rvalid_i,
  input  logic [31:0]  obi_rdata_i
);

  logic        outstanding_q;
  logic        pending_q;
  logic        slot_free;
  logic [31:0] addr_q;
  logic        we_q;
  logic [31:0] wdata_q;
  logic [1:0]  memtype_q;

  // Room for a new transaction if the old response lands this cycle
  assign slot_free = !outstanding_q || obi_rvalid_i;

  ////////////////////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////////////////////

  // Once issued, the request is replayed from the hold registers until gnt
  assign obi_req_o     = pending_q || (bus.trans_valid && slot_free);
  assign obi_addr_o    = pending_q ? addr_q    : bus.addr;
  assign obi_we_o      = pending_q ? we_q      : bus.we;
  assign obi_wdata_o   = pending_q ? wdata_q   : bus.wdata;
  assign obi_memtype_o = pending_q ? memtype_q : bus.memtype;

  assign bus.trans_ready = obi_gnt_i && (pending_q || slot_free);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= obi_req_o && !obi_gnt_i;
    end
  end

  // Capture fields on the first stalled cycle
  always_ff @(posedge clk) begin
    if (obi_req_o && !obi_gnt_i && !pending_q) begin
      addr_q    <= bus.addr;
      we_q      <= bus.we;
      wdata_q   <= bus.wdata;
      memtype_q <= bus.memtype;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////////////////////

  // Set wins, a new grant can coincide with the previous rvalid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= 1'b0;
    end else if (obi_req_o && obi_gnt_i) begin
      outstanding_q <= 1'b1;
    end else if (obi_rvalid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  assign bus.resp_valid       = obi_rvalid_i;
  assign bus.resp_data        = obi_rdata_i;
  assign bus.resp_outstanding = outstanding_q;

endmodule

/* verilog/mpu_top.sv */
`timescale 1ns/100ps

module mpu_top import mpu_pkg::*; #(
  parameter int       PMA_NUM_REGIONS = 4,
  // Listed from region 3 down to region 0
  parameter pma_cfg_t PMA_CFG [PMA_NUM_REGIONS-1:0] = '{
    // Region 3, I/O peripherals that accept posted writes
    '{word_addr_low: 30'h0400_0000, word_addr_high: 30'h0400_0400,
      main: 1'b0, atomic: 1'b0, bufferable: 1'b1, cacheable: 1'b0},
    // Region 2, main memory without atomics
    '{word_addr_low: 30'h0000_4000, word_addr_high: 30'h0000_8000,
      main: 1'b1, atomic: 1'b0, bufferable: 1'b0, cacheable: 1'b1},
    // Region 1, I/O window shadowed by region 0 in its lower half
    '{word_addr_low: 30'h0000_1800, word_addr_high: 30'h0000_2800,
      main: 1'b0, atomic: 1'b0, bufferable: 1'b0, cacheable: 1'b0},
    // Region 0, main memory
    '{word_addr_low: 30'h0000_0000, word_addr_high: 30'h0000_2000,
      main: 1'b1, atomic: 1'b1, bufferable: 1'b1, cacheable: 1'b1}
  }
) (
  input  logic         clk,
  input  logic         rst_n,

  // Core side
  input  logic         core_valid_i,
  output logic         core_ready_o,
  input  logic [31:0]  core_addr_i,
  input  logic         core_we_i,
  input  logic         core_atomic_i,
  input  logic [31:0]  core_wdata_i,
  output logic         core_rvalid_o,
  output logic [31:0]  core_rdata_o,
  output mpu_status_e  core_status_o,

  // OBI side
  output logic         obi_req_o,
  input  logic         obi_gnt_i,
  output logic [31:0]  obi_addr_o,
  output logic         obi_we_o,
  output logic [31:0]  obi_wdata_o,
  output logic [1:0]   obi_memtype_o,
  input  logic         obi_rvalid_i,
  input  logic [31:0]  obi_rdata_i
);

  pma_cfg_t pma_cfg;
  logic     pma_err;
  logic     misaligned;
  logic     atomic;

  mpu_bus_if bus_if ();

  pma_lookup #(
    .PMA_NUM_REGIONS (PMA_NUM_REGIONS),
    .PMA_CFG         (PMA_CFG)
  ) u_pma_lookup (
    .addr_i       (core_addr_i),
    .atomic_i     (atomic),
    .misaligned_i (misaligned),
    .pma_cfg_o    (pma_cfg),
    .pma_err_o    (pma_err)
  );

  mpu_ctrl u_mpu_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .core_valid_i  (core_valid_i),
    .core_ready_o  (core_ready_o),
    .core_addr_i   (core_addr_i),
    .core_we_i     (core_we_i),
    .core_atomic_i (core_atomic_i),
    .core_wdata_i  (core_wdata_i),
    .core_rvalid_o (core_rvalid_o),
    .core_rdata_o  (core_rdata_o),
    .core_status_o (core_status_o),
    .pma_cfg_i     (pma_cfg),
    .pma_err_i     (pma_err),
    .misaligned_o  (misaligned),
    .atomic_o      (atomic),
    .bus           (bus_if.master)
  );

  obi_port u_obi_port (
    .clk           (clk),
    .rst_n         (rst_n),
    .bus           (bus_if.slave),
    .obi_req_o     (obi_req_o),
    .obi_gnt_i     (obi_gnt_i),
    .obi_addr_o    (obi_addr_o),
    .obi_we_o      (obi_we_o),
    .obi_wdata_o   (obi_wdata_o),
    .obi_memtype_o (obi_memtype_o),
    .obi_rvalid_i  (obi_rvalid_i),
    .obi_rdata_i   (obi_rdata_i)
  );

endmodule

/* dv/mpu_props.sv */
`timescale 1ns/100ps

module mpu_props (
  input logic clk,
  input logic rst_n,
  input logic core_valid,
  input logic pma_err,
  input logic trans_ready,
  input logic resp_valid,
  input logic resp_outstanding,
  input logic err_resp,
  input logic block_core
);

  // A refused access must never be granted on the bus
  no_req_on_err: assert property (@(posedge clk) disable iff (!rst_n)
    !(core_valid && pma_err && trans_ready))
    else $error("bus grant seen for a refused access");

  no_resp_collision: assert property (@(posedge clk) disable iff (!rst_n)
    !(resp_valid && err_resp))
    else $error("bus response and error response in the same cycle");

  // The MPU holds the core only while a response is still owed
  block_while_owed: assert property (@(posedge clk) disable iff (!rst_n)
    block_core |-> (resp_outstanding || err_resp))
    else $error("core blocked by the MPU with no response owed");

endmodule

bind mpu_ctrl mpu_props u_mpu_props (
  .clk              (clk),
  .rst_n            (rst_n),
  .core_valid       (core_valid_i),
  .pma_err          (pma_err_i),
  .trans_ready      (bus.trans_ready),
  .resp_valid       (bus.resp_valid),
  .resp_outstanding (bus.resp_outstanding),
  .err_resp         (mpu_err_trans_valid),
  .block_core       (mpu_block_core)
);

/* dv/mpu_checker.sv */
`timescale 1ns/100ps

module mpu_checker import mpu_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        core_ready_i,
  input  logic        core_rvalid_i,
  input  logic [31:0] core_rdata_i,
  input  mpu_status_e core_status_i,
  input  logic        obi_req_i,
  input  logic        obi_gnt_i,
  input  logic [31:0] obi_addr_i,
  input  logic        obi_we_i,
  input  logic [31:0] obi_wdata_i,
  input  logic [1:0]  obi_memtype_i,
  output int          done_count_o,
  output int          fail_count_o
);

  typedef struct packed {
    logic [15:0] id;
    logic [31:0] addr;
    logic        we;
    logic [31:0] wdata;
    logic [1:0]  memtype;
    logic [31:0] rdata;
    logic        err;
  } exp_t;

  exp_t        req_q[$];
  exp_t        resp_q[$];
  logic        bad [65536];
  int          bad_tests = 0;
  logic        held = 1'b0;
  logic [66:0] held_fields;

  initial begin
    done_count_o = 0;
    fail_count_o = 0;
    foreach (bad[k]) bad[k] = 1'b0;
  end

  task automatic add_expected(input int id, input logic [31:0] addr, input logic we,
                              input logic [31:0] wdata, input logic [1:0] memtype,
                              input logic [31:0] rdata, input logic err);
    exp_t e;
    e = '{id: id[15:0], addr: addr, we: we, wdata: wdata, memtype: memtype,
          rdata: rdata, err: err};
    resp_q.push_back(e);
    // Refused accesses never reach the bus
    if (!err) req_q.push_back(e);
  endtask

  task automatic report_mismatch(input logic [15:0] id, input string msg);
    $display("[FAIL] %0t test %0d: %s", $time, id, msg);
    fail_count_o++;
    bad[id] = 1'b1;
  endtask

  task automatic print_summary();
    $display("Tests done %0d, tests failed %0d, checks failed %0d",
             done_count_o, bad_tests, fail_count_o);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare at the falling edge, where DUT outputs have settled
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    exp_t e;
    if (rst_n) begin
      if (obi_req_i) begin
        if (held && held_fields != {obi_addr_i, obi_we_i, obi_wdata_i, obi_memtype_i})
          report_mismatch(16'hffff, "OBI request changed while waiting for grant");
        if (core_ready_i != obi_gnt_i)
          report_mismatch(16'hffff, "core ready does not follow OBI grant");
        held        = !obi_gnt_i;
        held_fields = {obi_addr_i, obi_we_i, obi_wdata_i, obi_memtype_i};
        if (obi_gnt_i) begin
          if (req_q.size() == 0) begin
            report_mismatch(16'hffff, "OBI request granted with none expected");
          end else begin
            e = req_q.pop_front();
            if (obi_addr_i != e.addr || obi_we_i != e.we)
              report_mismatch(e.id, "wrong OBI address or write flag");
            if (e.we && obi_wdata_i != e.wdata)
              report_mismatch(e.id, "wrong OBI write data");
            if (obi_memtype_i != e.memtype)
              report_mismatch(e.id, "wrong OBI memtype");
          end
        end
      end else begin
        held = 1'b0;
      end

      if (core_rvalid_i) begin
        if (resp_q.size() == 0) begin
          report_mismatch(16'hffff, "core response with no access pending");
        end else begin
          e = resp_q.pop_front();
          if (core_status_i != (e.err ? MPU_ERR : MPU_OK))
            report_mismatch(e.id, "wrong response status");
          if (core_rdata_i != (e.err ? 32'h0 : e.rdata))
            report_mismatch(e.id, "wrong response data");
          if (bad[e.id]) bad_tests++;
          $display("test %0d: %s", e.id, bad[e.id] ? "mismatch" : "ok");
          done_count_o++;
        end
      end
    end
  end

endmodule

/* dv/mpu_tb.sv */
`timescale 1ns/100ps

module mpu_tb import mpu_pkg::*; ();

  localparam int          MAX_VEC       = 64;
  localparam logic [31:0] RDATA_PATTERN = 32'ha5a5_0f0f;

  logic        clk;
  logic        rst_n;
  logic        core_valid;
  logic        core_ready;
  logic [31:0] core_addr;
  logic        core_we;
  logic        core_atomic;
  logic [31:0] core_wdata;
  logic        core_rvalid;
  logic [31:0] core_rdata;
  mpu_status_e core_status;
  logic        obi_req;
  logic        obi_gnt;
  logic [31:0] obi_addr;
  logic        obi_we;
  logic [31:0] obi_wdata;
  logic [1:0]  obi_memtype;
  logic        obi_rvalid;
  logic [31:0] obi_rdata;

  // Vector table
  int          num_vec;
  logic        load_error;
  logic [31:0] vec_addr  [MAX_VEC];
  logic        vec_we    [MAX_VEC];
  logic        vec_atom  [MAX_VEC];
  logic [31:0] vec_wdata [MAX_VEC];
  int          vec_dly   [MAX_VEC];
  int          gnt_delay;
  int          wait_cnt;
  int          cycles;
  int          cycle_limit;
  int          done_count;
  int          fail_count;

  mpu_top UUT (
    .clk (clk), .rst_n (rst_n),
    .core_valid_i (core_valid), .core_ready_o (core_ready),
    .core_addr_i (core_addr), .core_we_i (core_we),
    .core_atomic_i (core_atomic), .core_wdata_i (core_wdata),
    .core_rvalid_o (core_rvalid), .core_rdata_o (core_rdata),
    .core_status_o (core_status),
    .obi_req_o (obi_req), .obi_gnt_i (obi_gnt), .obi_addr_o (obi_addr),
    .obi_we_o (obi_we), .obi_wdata_o (obi_wdata), .obi_memtype_o (obi_memtype),
    .obi_rvalid_i (obi_rvalid), .obi_rdata_i (obi_rdata)
  );

  mpu_checker u_checker (
    .clk (clk), .rst_n (rst_n),
    .core_ready_i (core_ready), .core_rvalid_i (core_rvalid),
    .core_rdata_i (core_rdata), .core_status_i (core_status),
    .obi_req_i (obi_req), .obi_gnt_i (obi_gnt), .obi_addr_i (obi_addr),
    .obi_we_i (obi_we), .obi_wdata_i (obi_wdata), .obi_memtype_i (obi_memtype),
    .done_count_o (done_count), .fail_count_o (fail_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // OBI memory model
  ////////////////////////////////////////////////////////////////////////////

  // Grant after gnt_delay stalled cycles, answer one cycle after the grant
  assign obi_gnt = obi_req && (wait_cnt >= gnt_delay);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_cnt   <= 0;
      obi_rvalid <= 1'b0;
      obi_rdata  <= 32'h0;
    end else begin
      obi_rvalid <= obi_req && obi_gnt;
      obi_rdata  <= (obi_req && obi_gnt) ? (obi_addr ^ RDATA_PATTERN) : 32'h0;
      wait_cnt   <= (obi_req && !obi_gnt) ? wait_cnt + 1 : 0;
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout: the DUT did not answer every access in %0d cycles", cycle_limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Vector reader and stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          fd;
    int          cnt;
    int          id;
    int          we;
    int          at;
    int          dly;
    int          st;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] mt;
    logic [31:0] rdata;
    string       line;
    int          i;

    core_valid  = 1'b0;
    core_addr   = 32'h0;
    core_we     = 1'b0;
    core_atomic = 1'b0;
    core_wdata  = 32'h0;
    gnt_delay   = 0;
    cycles      = 0;
    rst_n       = 1'b0;
    num_vec     = 0;
    load_error  = 1'b0;

    fd = $fopen("dv/mpu_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file dv/mpu_vectors.txt");
      load_error = 1'b1;
    end else begin
      while (!$feof(fd) && num_vec < MAX_VEC) begin
        line = "";
        cnt  = $fgets(line, fd);
        if (line.len() > 0 && line.getc(0) != 8'h23) begin
          cnt = $sscanf(line, "%d %h %d %d %h %d %d %h %h",
                        id, addr, we, at, wdata, dly, st, mt, rdata);
          if (cnt == 9) begin
            vec_addr[num_vec]  = addr;
            vec_we[num_vec]    = (we != 0);
            vec_atom[num_vec]  = (at != 0);
            vec_wdata[num_vec] = wdata;
            vec_dly[num_vec]   = dly;
            u_checker.add_expected(id, addr, (we != 0), wdata, mt[1:0], rdata, (st != 0));
            num_vec++;
          end
        end
      end
      $fclose(fd);
    end
    cycle_limit = num_vec * 20 + 10;

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Hold each request until the cycle where ready is seen high
    for (i = 0; i < num_vec; i++) begin
      core_valid  <= 1'b1;
      core_addr   <= vec_addr[i];
      core_we     <= vec_we[i];
      core_atomic <= vec_atom[i];
      core_wdata  <= vec_wdata[i];
      gnt_delay   <= vec_dly[i];
      do @(negedge clk); while (!core_ready);
      @(posedge clk);
    end
    core_valid <= 1'b0;

    while (done_count < num_vec) @(posedge clk);
    repeat (2) @(posedge clk);
    u_checker.print_summary();
    if (fail_count != 0 || load_error || num_vec == 0) begin
      $display("STATUS: FAIL");
    end else begin
      $display("STATUS: PASS");
    end
    $finish;
  end

endmodule

/* dv/mpu_vectors.txt */
# id addr we atomic wdata gnt_delay status(0 ok,1 err) memtype rdata (hex: addr wdata memtype rdata)
# Expected read data is the address XOR a5a50f0f; refused accesses expect zero
1 00000100 0 0 00000000 0 0 2 a5a50e0f
2 00000104 1 0 deadbeef 0 0 3 a5a50e0b
3 10000010 1 0 12345678 0 0 1 b5a50f1f
4 10000020 0 0 00000000 0 0 0 b5a50f2f
5 10000022 0 0 00000000 0 1 0 00000000
6 00010000 1 1 11111111 0 1 0 00000000
7 40000000 0 0 00000000 0 1 0 00000000
8 00006000 1 0 0badf00d 0 0 3 a5a56f0f
9 00009000 1 0 22222222 0 0 0 a5a59f0f
10 00010004 1 0 33333333 0 0 2 a5a40f0b
11 00000200 1 1 44444444 0 0 2 a5a50d0f
12 00000300 0 0 00000000 0 0 2 a5a50c0f
13 40000004 0 0 00000000 0 1 0 00000000
14 00000400 1 0 cafef00d 5 0 3 a5a50b0f
15 00010008 0 0 00000000 3 0 2 a5a40f07
16 00010010 0 1 00000000 0 1 0 00000000
17 00000006 0 0 00000000 0 0 2 a5a50f09
18 00000010 0 1 00000000 2 0 2 a5a50f1f

/* sources.f */
verilog/mpu_pkg.sv
verilog/mpu_bus_if.sv
verilog/pma_lookup.sv
verilog/mpu_ctrl.sv
verilog/obi_port.sv
verilog/mpu_top.sv
dv/mpu_props.sv
dv/mpu_checker.sv
dv/mpu_tb.sv

/* Makefile */
SIM := obj_dir/mpu_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module mpu_tb -o mpu_sim

run: compile
	./$(SIM) | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
